// File: hdl/rr_burst_mux_settings.svh
`ifndef RR_BURST_MUX_SETTINGS_SVH
`define RR_BURST_MUX_SETTINGS_SVH

// ------------------------------------------------------------
// Channel sizing
// ------------------------------------------------------------

// Number of clients that share the output channel
`define RR_NUM_CLIENTS 4

// Width of one data word carried per beat
`define RR_DATA_W 16

// Width of the burst length field
// A length value L stands for L+1 beats on the channel
`define RR_LEN_W 3

`endif

// File: hdl/rr_mux_data_pkg.sv
`include "rr_burst_mux_settings.svh"

package rr_mux_data_pkg;

  // ------------------------------------------------------------
  // Scalar payload fields
  // ------------------------------------------------------------

  // Index of one client, wide enough for every requester
  typedef logic [$clog2(`RR_NUM_CLIENTS)-1:0] client_idx_t;

  // Burst length as presented by a client, L means L+1 beats
  typedef logic [`RR_LEN_W-1:0] burst_len_t;

  // One word of burst data
  typedef logic [`RR_DATA_W-1:0] data_word_t;

  // ------------------------------------------------------------
  // Composite payloads
  // ------------------------------------------------------------

  // What a client drives toward the multiplexer
  // The length is only looked at in the grant cycle
  // The data word is replaced after every beat_ack
  typedef struct packed {
    burst_len_t len;
    data_word_t data;
  } client_word_t;

  // One registered beat on the output channel
  // Last marks the final beat of a burst and client names its owner
  typedef struct packed {
    logic        valid;
    logic        last;
    client_idx_t client;
    data_word_t  data;
  } out_beat_t;

endpackage

// File: hdl/rr_mux_ctrl_pkg.sv
`include "rr_burst_mux_settings.svh"

package rr_mux_ctrl_pkg;

  // Channel ownership state of the burst FSM
  typedef enum logic {
    CH_IDLE = 1'b0,
    CH_XFER = 1'b1
  } chan_state_t;

  // Record of one arbitration decision, kept for the whole burst
  typedef struct packed {
    logic                         valid;
    rr_mux_data_pkg::client_idx_t client;
  } grant_rec_t;

  // Converts a one-hot (or all-zero) grant vector into a client index
  // An all-zero vector maps to index 0
  function automatic rr_mux_data_pkg::client_idx_t onehot_to_idx(
    input logic [`RR_NUM_CLIENTS-1:0] onehot
  );
    rr_mux_data_pkg::client_idx_t idx;
    idx = '0;
    for (int i = 0; i < `RR_NUM_CLIENTS; i++) begin
      if (onehot[i]) begin
        idx = idx | rr_mux_data_pkg::client_idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

// File: hdl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
  // Two or more requesters
  parameter int num_requesters = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enable,
  input  logic [num_requesters-1:0] request,
  output logic [num_requesters-1:0] grant
);

  // Index of a single requester
  typedef logic [$clog2(num_requesters)-1:0] idx_t;

  // ------------------------------------------------------------
  // Priority rotation
  // ------------------------------------------------------------

  // The last granted requester has the lowest priority
  // Everything above it in index order is searched first, then the search wraps
  logic [num_requesters-1:0] priority_mask;
  logic [num_requesters-1:0] request_high;
  logic [num_requesters-1:0] grant_high;
  logic [num_requesters-1:0] grant_low;
  idx_t                      last_grant;
  idx_t                      last_grant_next;

  // Bit i survives the mask only if it sits above the last grant
  always_comb begin
    for (int i = 0; i < num_requesters; i++) begin
      priority_mask[i] = (i > int'(last_grant));
    end
  end

  assign request_high = request & priority_mask;

  // Lowest set bit of each vector, found with the two's complement trick
  assign grant_high = request_high & (~request_high + 1'b1);
  assign grant_low  = request & (~request + 1'b1);

  // The wrapped search only matters when nothing above the last grant asks
  // Enable gates the grant, so the priority also holds while disabled
  assign grant = {num_requesters{enable}} & ((|request_high) ? grant_high : grant_low);

  // ------------------------------------------------------------
  // Last-grant register
  // ------------------------------------------------------------

  // Binary index of the one-hot grant
  always_comb begin
    last_grant_next = '0;
    for (int i = 0; i < num_requesters; i++) begin
      if (grant[i]) begin
        last_grant_next = last_grant_next | idx_t'(i);
      end
    end
  end

  // Starts at the top index so requester 0 wins first out of reset
  // Any request while enabled always produces a grant, hence the simple load term
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_grant <= idx_t'(num_requesters - 1);
    end else if (enable && (|request)) begin
      last_grant <= last_grant_next;
    end
  end

endmodule

// File: hdl/burst_ctrl_fsm.sv
`timescale 1ns/1ps
`include "rr_burst_mux_settings.svh"

module burst_ctrl_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`RR_NUM_CLIENTS-1:0]   grant,
  input  logic                         stall,
  input  logic                         last_beat,
  output logic                         arb_enable,
  output logic                         start,
  output logic                         take,
  output rr_mux_ctrl_pkg::grant_rec_t  rec,
  output logic [`RR_NUM_CLIENTS-1:0]   beat_ack,
  output logic                         out_valid,
  output logic                         out_last,
  output rr_mux_data_pkg::client_idx_t out_client
);

  import rr_mux_ctrl_pkg::*;

  chan_state_t state;
  chan_state_t state_next;
  logic        burst_end;

  // ------------------------------------------------------------
  // Strobes
  // ------------------------------------------------------------

  // The arbiter may only pick a client while nobody owns the channel
  assign arb_enable = (state == CH_IDLE);

  // A grant in the idle state opens a burst in the same cycle
  assign start = arb_enable & (|grant);

  // One beat moves in every transfer cycle the sink does not stall
  assign take = (state == CH_XFER) & ~stall;

  // The take of the last counted beat closes the burst
  assign burst_end = take & last_beat;

  // Only the owning client is told that its word was consumed
  always_comb begin
    beat_ack = '0;
    if (take) begin
      beat_ack[rec.client] = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Channel state
  // ------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      CH_IDLE: begin
        if (start) begin
          state_next = CH_XFER;
        end
      end
      CH_XFER: begin
        if (burst_end) begin
          state_next = CH_IDLE;
        end
      end
      default: begin
        state_next = CH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= CH_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Grant record is captured on start and released with the final beat
  // A stall leaves it untouched since neither event fires then
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rec <= '0;
    end else if (start) begin
      rec <= '{valid: 1'b1, client: onehot_to_idx(grant)};
    end else if (burst_end) begin
      rec.valid <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Output beat flags
  // ------------------------------------------------------------

  // These line up with the data register that also loads on take
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= take;
      out_last  <= burst_end;
    end
  end

  // Owner tag of the beat, only meaningful while out_valid is high
  always_ff @(posedge clk) begin
    if (take) begin
      out_client <= rec.client;
    end
  end

endmodule

// File: hdl/beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       load,
  input  rr_mux_data_pkg::burst_len_t load_len,
  input  logic                       dec,
  output logic                       last_beat
);

  import rr_mux_data_pkg::*;

  burst_len_t count;
  burst_len_t remaining;
  logic       load_d;

  // The length comes from the header register, which captures it on the load edge
  // So the fresh length is taken straight from load_len in the cycle after load
  assign remaining = load_d ? load_len : count;

  // Zero beats left after the current one means this beat closes the burst
  assign last_beat = (remaining == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_d <= 1'b0;
      count  <= '0;
    end else begin
      load_d <= load;
      // Saturate at zero, the FSM leaves the burst on that beat anyway
      if (dec && !last_beat) begin
        count <= remaining - 1'b1;
      end else begin
        count <= remaining;
      end
    end
  end

endmodule

// File: hdl/client_select.sv
`timescale 1ns/1ps
`include "rr_burst_mux_settings.svh"

module client_select #(
  // Payload that is picked per client, a length or a data word here
  parameter type payload_t   = logic [`RR_DATA_W-1:0],
  parameter int  num_clients = `RR_NUM_CLIENTS
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  rr_mux_data_pkg::client_idx_t sel,
  input  logic                         load,
  input  payload_t                     payloads [num_clients],
  output payload_t                     q
);

  payload_t picked;

  // ------------------------------------------------------------
  // Client mux
  // ------------------------------------------------------------

  // Plain index compare, so an index past the last client falls back to client 0
  always_comb begin
    picked = payloads[0];
    for (int i = 1; i < num_clients; i++) begin
      if (int'(sel) == i) begin
        picked = payloads[i];
      end
    end
  end

  // ------------------------------------------------------------
  // Capture register
  // ------------------------------------------------------------

  // Holds its value between loads, so the consumer sees a stable payload
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (load) begin
      q <= picked;
    end
  end

endmodule

// File: hdl/rr_burst_mux.sv
`timescale 1ns/1ps
`include "rr_burst_mux_settings.svh"

module rr_burst_mux (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [`RR_NUM_CLIENTS-1:0]                          req,
  input  rr_mux_data_pkg::client_word_t [`RR_NUM_CLIENTS-1:0] clients,
  input  logic                                                stall,
  output logic [`RR_NUM_CLIENTS-1:0]                          beat_ack,
  output rr_mux_data_pkg::out_beat_t                          out
);

  import rr_mux_data_pkg::*;
  import rr_mux_ctrl_pkg::*;

  // ------------------------------------------------------------
  // Internal nets
  // ------------------------------------------------------------

  logic [`RR_NUM_CLIENTS-1:0] grant;
  logic                       arb_enable;
  logic                       start;
  logic                       take;
  logic                       last_beat;
  grant_rec_t                 rec;
  client_idx_t                grant_idx;
  burst_len_t                 hdr_len;
  burst_len_t                 client_lens [`RR_NUM_CLIENTS];
  data_word_t                 client_data [`RR_NUM_CLIENTS];
  data_word_t                 out_data;
  logic                       out_valid;
  logic                       out_last;
  client_idx_t                out_client;

  // Split the client structs into one array per field for the two selectors
  always_comb begin
    for (int i = 0; i < `RR_NUM_CLIENTS; i++) begin
      client_lens[i] = clients[i].len;
      client_data[i] = clients[i].data;
    end
  end

  // Header select runs in the grant cycle, before the FSM has its record
  assign grant_idx = onehot_to_idx(grant);

  // ------------------------------------------------------------
  // Arbitration and burst control
  // ------------------------------------------------------------

  rr_arbiter #(
    .num_requesters(`RR_NUM_CLIENTS)
  ) arb0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (arb_enable),
    .request(req),
    .grant  (grant)
  );

  burst_ctrl_fsm fsm0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .stall     (stall),
    .last_beat (last_beat),
    .arb_enable(arb_enable),
    .start     (start),
    .take      (take),
    .rec       (rec),
    .beat_ack  (beat_ack),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_client(out_client)
  );

  beat_counter cnt0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (start),
    .load_len (hdr_len),
    .dec      (take),
    .last_beat(last_beat)
  );

  // ------------------------------------------------------------
  // Payload selectors
  // ------------------------------------------------------------

  // Length of the winning client, held for the whole burst
  client_select #(
    .payload_t  (burst_len_t),
    .num_clients(`RR_NUM_CLIENTS)
  ) hdr_sel0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (grant_idx),
    .load    (start),
    .payloads(client_lens),
    .q       (hdr_len)
  );

  // Data word of the owning client, one capture per taken beat
  client_select #(
    .payload_t  (data_word_t),
    .num_clients(`RR_NUM_CLIENTS)
  ) data_sel0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (rec.client),
    .load    (take),
    .payloads(client_data),
    .q       (out_data)
  );

  assign out = '{valid: out_valid, last: out_last, client: out_client, data: out_data};

endmodule

// File: testbench/rr_burst_mux_props.sv
`timescale 1ns/1ps
`include "rr_burst_mux_settings.svh"

module rr_burst_mux_props (
  input logic                        clk,
  input logic                        rst_n,
  input logic [`RR_NUM_CLIENTS-1:0]  req,
  input logic [`RR_NUM_CLIENTS-1:0]  grant,
  input rr_mux_ctrl_pkg::grant_rec_t rec,
  input logic                        stall,
  input logic [`RR_NUM_CLIENTS-1:0]  beat_ack,
  input rr_mux_data_pkg::out_beat_t  out
);

  // ------------------------------------------------------------
  // Arbiter
  // ------------------------------------------------------------

  // At most one client wins in a cycle
  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
    else $error("grant %b is not one-hot or zero", grant);

  // A grant only ever goes to a client that asks
  grant_has_req: assert property (@(posedge clk) disable iff (!rst_n) (grant & ~req) == '0)
    else $error("grant %b without request %b", grant, req);

  // The grant record stays valid for the whole burst and no new grant may appear then
  grant_when_idle: assert property (@(posedge clk) disable iff (!rst_n) (|grant) |-> !rec.valid)
    else $error("grant %b while client %0d owns the channel", grant, rec.client);

  // ------------------------------------------------------------
  // Transfer side
  // ------------------------------------------------------------

  beat_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(beat_ack))
    else $error("beat_ack %b acks more than one client", beat_ack);

  // A stalled cycle takes no beat, so the next output slot is empty
  stall_gap: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !out.valid)
    else $error("out.valid high one cycle after stall");

endmodule

bind rr_burst_mux rr_burst_mux_props props0 (
  .clk     (clk),
  .rst_n   (rst_n),
  .req     (req),
  .grant   (grant),
  .rec     (rec),
  .stall   (stall),
  .beat_ack(beat_ack),
  .out     (out)
);

// File: testbench/rr_burst_mux_tb.sv
`timescale 1ns/1ps
`include "rr_burst_mux_settings.svh"

module rr_burst_mux_tb;

  import rr_mux_data_pkg::*;
  import rr_mux_ctrl_pkg::*;

  localparam int NUM = `RR_NUM_CLIENTS;
  localparam int MIX_STEPS = 300;
  // Rough cycle budget of each test in run order
  localparam int T_RESET = 20;
  localparam int T_QUIET = 20;
  localparam int T_LENGTHS = 60;
  localparam int T_ROTATE = 40;
  localparam int T_SKIP = 30;
  localparam int T_STALL = 100;
  localparam int T_MIX = MIX_STEPS + 120;
  localparam int TIMEOUT_CYCLES =
    2 * (T_RESET + T_QUIET + T_LENGTHS + T_ROTATE + T_SKIP + T_STALL + T_MIX);

  logic                   clk;
  logic                   rst_n;
  logic [NUM-1:0]         req;
  client_word_t [NUM-1:0] clients;
  logic                   stall;
  logic [NUM-1:0]         beat_ack;
  out_beat_t              out;

  // Client models hold one queue of lengths and one of words per client
  int             len_q [NUM][$];
  data_word_t     word_q [NUM][$];
  data_word_t     exp_words [NUM][$];
  int             acks_done [NUM];
  logic [NUM-1:0] ack_seen;

  // Reference model of the channel that advances once per cycle
  chan_state_t m_state;
  int          m_last;
  int          m_client;
  int          m_left;
  logic        m_out_valid;
  logic        m_out_last;
  int          m_out_client;
  data_word_t  m_out_data;

  int          burst_log [$];
  int          exp_order [$];
  int          beats_seen;
  int          burst_seq;
  int          cycle_count;
  logic [15:0] lfsr_state;

  rr_burst_mux dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .clients (clients),
    .stall   (stall),
    .beat_ack(beat_ack),
    .out     (out)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ------------------------------------------------------------
  // Checker and random source
  // ------------------------------------------------------------

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Galois LFSR of 16 bits with taps 16 14 13 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // Collects n bits with one LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = next_lfsr(lfsr_state);
    end
    return v;
  endfunction

  // Round robin searches upward from the client after the last winner and wraps
  function automatic int rr_pick(input logic [NUM-1:0] r, input int last);
    int idx;
    for (int k = 1; k <= NUM; k++) begin
      idx = (last + k) % NUM;
      if (r[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  // ------------------------------------------------------------
  // Scoreboard sampled mid-cycle where everything is settled
  // ------------------------------------------------------------

  always @(negedge clk) begin
    logic [NUM-1:0] exp_ack;
    int             win;
    if (!rst_n) begin
      ack_seen = '0;
    end else begin
      check_eq("out.valid", 32'(out.valid), 32'(m_out_valid));
      if (m_out_valid) begin
        check_eq("out.client", 32'(out.client), m_out_client);
        check_eq("out.last", 32'(out.last), 32'(m_out_last));
        check_eq("out.data", 32'(out.data), 32'(m_out_data));
        beats_seen++;
        if (out.last) begin
          burst_log.push_back(int'(out.client));
        end
      end
      // Only the owner is acked, and only in a transfer cycle without stall
      exp_ack = '0;
      if (m_state == CH_XFER && !stall) begin
        exp_ack[m_client] = 1'b1;
      end
      check_eq("beat_ack", 32'(beat_ack), 32'(exp_ack));
      ack_seen = beat_ack;
      // Advance the model to the state after the coming edge
      m_out_valid = 1'b0;
      if (m_state == CH_IDLE) begin
        win = rr_pick(req, m_last);
        if (win >= 0) begin
          m_last   = win;
          m_client = win;
          m_left   = len_q[win][0];
          m_state  = CH_XFER;
        end
      end else if (!stall) begin
        if (exp_words[m_client].size() == 0) begin
          $display("Client %0d was asked for a word it never had", m_client);
          $display("TEST FAILED");
          $fatal(1, "word underflow");
        end
        m_out_valid  = 1'b1;
        m_out_client = m_client;
        m_out_last   = (m_left == 0);
        m_out_data   = exp_words[m_client].pop_front();
        if (m_left == 0) begin
          m_state = CH_IDLE;
        end else begin
          m_left--;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------------------------------------
  // Client models and stimulus helpers
  // ------------------------------------------------------------

  // Pops the word acked last cycle and presents the new head of each queue
  task automatic drive_clients();
    for (int i = 0; i < NUM; i++) begin
      if (ack_seen[i] && len_q[i].size() > 0) begin
        void'(word_q[i].pop_front());
        acks_done[i]++;
        if (acks_done[i] == len_q[i][0] + 1) begin
          void'(len_q[i].pop_front());
          acks_done[i] = 0;
        end
      end
      // A client keeps asking as long as it holds another burst
      req[i]          = (len_q[i].size() > 0);
      clients[i].len  = (len_q[i].size() > 0) ? burst_len_t'(len_q[i][0]) : '0;
      clients[i].data = (word_q[i].size() > 0) ? word_q[i][0] : '0;
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
    drive_clients();
  endtask

  // Queues L+1 words for client c with tagged or random data
  task automatic add_burst(input int c, input int len, input bit random_data);
    data_word_t w;
    len_q[c].push_back(len);
    for (int k = 0; k <= len; k++) begin
      if (random_data) begin
        w = data_word_t'(take_bits(16));
      end else begin
        w = {2'(c), 8'(burst_seq), 3'(len), 3'(k)};
      end
      word_q[c].push_back(w);
      exp_words[c].push_back(w);
    end
    burst_seq++;
  endtask

  // Runs until every queued word was acked and the output went quiet
  task automatic wait_drained(input bit random_stall);
    int quiet;
    int pending;
    quiet = 0;
    while (quiet < 3) begin
      step_cycle();
      stall = random_stall ? (take_bits(1) != 32'd0) : 1'b0;
      pending = 0;
      for (int i = 0; i < NUM; i++) begin
        pending += word_q[i].size();
      end
      quiet = (pending == 0 && !out.valid) ? quiet + 1 : 0;
    end
    stall = 1'b0;
  endtask

  task automatic check_order();
    check_eq("burst_log.size", burst_log.size(), exp_order.size());
    foreach (exp_order[k]) begin
      check_eq($sformatf("burst_log[%0d]", k), burst_log[k], exp_order[k]);
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic quiet_after_reset();
    for (int n = 0; n < 20; n++) begin
      step_cycle();
      check_eq("out.valid", 32'(out.valid), 32'd0);
      check_eq("beat_ack", 32'(beat_ack), 32'd0);
    end
  endtask

  task automatic single_client_lengths();
    for (int len = 0; len < 8; len++) begin
      add_burst(1, len, 1'b0);
    end
    wait_drained(1'b0);
  endtask

  // Client 3 goes first so that client 0 has top priority afterwards
  task automatic full_rotation();
    add_burst(3, 0, 1'b0);
    wait_drained(1'b0);
    burst_log.delete();
    add_burst(0, 1, 1'b0);
    add_burst(0, 2, 1'b0);
    add_burst(1, 2, 1'b0);
    add_burst(2, 0, 1'b0);
    add_burst(3, 3, 1'b0);
    wait_drained(1'b0);
    exp_order = '{0, 1, 2, 3, 0};
    check_order();
  endtask

  task automatic rotation_skip();
    burst_log.delete();
    add_burst(2, 1, 1'b0);
    wait_drained(1'b0);
    add_burst(1, 2, 1'b0);
    add_burst(3, 1, 1'b0);
    wait_drained(1'b0);
    exp_order = '{2, 3, 1};
    check_order();
  endtask

  task automatic stalled_bursts();
    burst_log.delete();
    beats_seen = 0;
    add_burst(0, 7, 1'b0);
    add_burst(2, 7, 1'b0);
    add_burst(3, 7, 1'b0);
    wait_drained(1'b1);
    exp_order = '{2, 3, 0};
    check_order();
    check_eq("beats_seen", beats_seen, 24);
  endtask

  // Every queued burst must come out once with all of its beats
  task automatic random_mix();
    int c;
    int len;
    int bursts_added;
    int words_added;
    burst_log.delete();
    beats_seen   = 0;
    bursts_added = 0;
    words_added  = 0;
    for (int n = 0; n < MIX_STEPS; n++) begin
      step_cycle();
      stall = (take_bits(2) == 32'd3);
      if (take_bits(3) == 32'd0) begin
        c = int'(take_bits(2));
        if (len_q[c].size() < 2) begin
          len = int'(take_bits(3));
          add_burst(c, len, 1'b1);
          bursts_added++;
          words_added += len + 1;
        end
      end
    end
    wait_drained(1'b0);
    check_eq("burst_log.size", burst_log.size(), bursts_added);
    check_eq("beats_seen", beats_seen, words_added);
  endtask

  initial begin
    rst_n       = 1'b0;
    stall       = 1'b0;
    req         = '0;
    clients     = '0;
    ack_seen    = '0;
    lfsr_state  = 16'd61;
    m_state     = CH_IDLE;
    m_last      = NUM - 1;
    m_client    = 0;
    m_left      = 0;
    m_out_valid = 1'b0;
    beats_seen  = 0;
    burst_seq   = 0;
    cycle_count = 0;
    foreach (acks_done[i]) begin
      acks_done[i] = 0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    quiet_after_reset();
    single_client_lengths();
    full_rotation();
    rotation_skip();
    stalled_bursts();
    random_mix();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: rr_burst_mux.f
+incdir+hdl
hdl/rr_mux_data_pkg.sv
hdl/rr_mux_ctrl_pkg.sv
hdl/rr_arbiter.sv
hdl/burst_ctrl_fsm.sv
hdl/beat_counter.sv
hdl/client_select.sv
hdl/rr_burst_mux.sv
testbench/rr_burst_mux_props.sv
testbench/rr_burst_mux_tb.sv

// File: Makefile
# Verilator build and run for rr_burst_mux
# Any variable can be overridden, for example: make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= rr_burst_mux_tb
FILELIST  ?= rr_burst_mux.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

# Sources come from the file list, headers from the include folder
SRCS    := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# The simulator's own exit status is ignored, the log decides
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
